// File: astro_input.f
rtl/astro_input_pkg.sv
rtl/game_select.sv
rtl/ps2_button_decoder.sv
rtl/paddle_conditioner.sv
rtl/stick_axis_decoder.sv
rtl/control_port_mux.sv
rtl/astro_input_top.sv
testbench/tb_clock_gen.sv
testbench/astro_input_chk.sv
testbench/astro_input_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= astro_input_tb
FLAGS     ?= --assert

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f astro_input.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// File: testbench/astro_input_tb.sv
`timescale 1ns/1ps

module astro_input_tb
	import astro_input_pkg::*;
;

	localparam int MAX_ROWS = 80;

	typedef struct packed {
		logic [7:0]  game;
		logic [7:0]  d0;
		logic [7:0]  d2;
		logic [7:0]  d3;
		logic [15:0] j0;
		logic [15:0] j1;
		logic [15:0] a0;
		logic [15:0] a1;
		logic [7:0]  col;
		logic [7:0]  exp;
		logic [1:0]  key_mode;  // 0 none, 1 event, 2 code without toggle
		logic        key_press;
		logic [8:0]  key_code;
		logic        stray_en;  // extra write that must not land
		logic [7:0]  stray_idx;
		logic [24:0] stray_addr;
		logic        rnd;       // random joystick words
	} row_t;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [10:0] ps2_key;
	logic [15:0] joystick_0;
	logic [15:0] joystick_1;
	logic [15:0] joystick_analog_0;
	logic [15:0] joystick_analog_1;
	logic [7:0]  col_select;
	logic [7:0]  row_data;

	row_t table_rows [MAX_ROWS];
	int   num_rows;
	int   errors;
	logic key_toggle;  // last toggle sent
	logic table_ready;

	tb_clock_gen tb_clock_gen_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	astro_input_top astro_input_top_i (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.ioctl_wr          (ioctl_wr),
		.ioctl_index       (ioctl_index),
		.ioctl_addr        (ioctl_addr),
		.ioctl_dout        (ioctl_dout),
		.ps2_key           (ps2_key),
		.joystick_0        (joystick_0),
		.joystick_1        (joystick_1),
		.joystick_analog_0 (joystick_analog_0),
		.joystick_analog_1 (joystick_analog_1),
		.col_select        (col_select),
		.row_data          (row_data)
	);

	// ==========================================================
	// Table building
	// ==========================================================
	task automatic add_row(input logic [7:0] game, input logic [7:0] d0, input logic [7:0] d2,
	                       input logic [7:0] d3, input logic [15:0] j0, input logic [15:0] j1,
	                       input logic [15:0] a0, input logic [15:0] a1, input logic [7:0] col,
	                       input logic [7:0] exp);
		row_t r;
		r = '0;
		r.game = game;
		r.d0   = d0;
		r.d2   = d2;
		r.d3   = d3;
		r.j0   = j0;
		r.j1   = j1;
		r.a0   = a0;
		r.a1   = a1;
		r.col  = col;
		r.exp  = exp;
		table_rows[num_rows] = r;
		num_rows++;
	endtask

	task automatic with_key(input logic [1:0] mode, input logic press, input logic [8:0] code);
		table_rows[num_rows-1].key_mode  = mode;
		table_rows[num_rows-1].key_press = press;
		table_rows[num_rows-1].key_code  = code;
	endtask

	task automatic with_stray(input logic [7:0] idx, input logic [24:0] addr);
		table_rows[num_rows-1].stray_en   = 1'b1;
		table_rows[num_rows-1].stray_idx  = idx;
		table_rows[num_rows-1].stray_addr = addr;
	endtask

	task automatic with_random();
		table_rows[num_rows-1].rnd = 1'b1;
	endtask

	// Player rows of the digital games, keys released
	function automatic logic [7:0] digital_row(input logic [7:0] game, input logic [7:0] d2,
	                                           input logic [7:0] col, input logic [15:0] j0,
	                                           input logic [15:0] j1);
		logic [15:0] j;
		logic [3:0]  dir_n;
		logic [7:0]  row;
		j     = (col == COL_1) ? j1 : j0;
		dir_n = ~{j[0], j[1], j[2], j[3]}; // R L D U
		row   = ROW_IDLE;
		if (game == GAME_SPACEZAP) begin
			row = (col == COL_1) ? {3'b111, ~j[4], dir_n} : {2'b11, d2[0], ~j[4], dir_n};
		end else if (game == GAME_GORF) begin
			row = (col == COL_1) ? {3'b001, ~j[4], dir_n} : {3'b101, ~j[4], dir_n};
		end else if (game == GAME_ROBBY) begin
			row = {2'b11, ~j[4], 1'b1, dir_n};
		end
		return row;
	endfunction

	task automatic fill_table();
		num_rows = 0;
		// Reset state, DIP column, stray writes
		add_row(8'd0, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hFF);
		add_row(8'd0, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_1, 8'hFF);
		add_row(8'd0, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hFF);
		add_row(8'd0, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_3, 8'h00);
		add_row(8'd0, 8'h00, 8'h00, 8'h5A, 16'h0, 16'h0, 16'h0, 16'h0, COL_3, 8'h5A);
		// Address 4 aliases bank 0, which would turn on the WoW stick
		add_row(GAME_WOW, 8'h00, 8'h00, 8'h5A, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hEF);
		with_stray(IDX_DIPS, 25'd4);
		add_row(8'd0, 8'h00, 8'h00, 8'h5A, 16'h0, 16'h0, 16'h0, 16'h0, COL_3, 8'h5A);
		with_stray(8'd7, 25'd3);
		add_row(8'd0, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 8'h10, 8'hFF);
		// Column 0 per game, id 2 selects nothing
		add_row(8'd2, 8'h00, 8'h03, 8'h00, 16'h040, 16'h0, 16'h0, 16'h0, COL_0, 8'hFF);
		add_row(GAME_SPACEZAP, 8'h00, 8'h03, 8'h00, 16'h040, 16'h0, 16'h0, 16'h0, COL_0, 8'hEF);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h100, 16'h0, 16'h0, 16'h0, COL_0, 8'hF5);
		add_row(GAME_GORF, 8'h00, 8'h01, 8'h00, 16'h080, 16'h0, 16'h0, 16'h0, COL_0, 8'h5B);
		add_row(GAME_WOW, 8'h00, 8'h04, 8'h00, 16'h040, 16'h0, 16'h0, 16'h0, COL_0, 8'hD7);
		add_row(GAME_ROBBY, 8'h00, 8'h02, 8'h00, 16'h100, 16'h0, 16'h0, 16'h0, COL_0, 8'h7D);
		// Keyboard, Space Zap
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hCF);
		with_key(2'd1, 1'b1, KEY_FIRE1);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hCE);
		with_key(2'd1, 1'b1, {1'b1, KEY_UP});  // extended code
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hDE);
		with_key(2'd1, 1'b0, KEY_FIRE1);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hDF);
		with_key(2'd1, 1'b0, {1'b0, KEY_UP});
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_2, 8'hDF);
		with_key(2'd2, 1'b1, KEY_FIRE1);       // no toggle, ignored
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_1, 8'hEF);
		with_key(2'd1, 1'b1, KEY_P2_FIRE1);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_1, 8'hE7);
		with_key(2'd1, 1'b1, KEY_P2_RIGHT);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_1, 8'hF7);
		with_key(2'd1, 1'b0, KEY_P2_FIRE1);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_1, 8'hFF);
		with_key(2'd1, 1'b0, KEY_P2_RIGHT);
		// Start and coin, F-key and MAME held apart
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hE7);
		with_key(2'd1, 1'b1, KEY_START1_F);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hE7);
		with_key(2'd1, 1'b1, KEY_START1);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hE7);
		with_key(2'd1, 1'b0, KEY_START1_F);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hF7);
		with_key(2'd1, 1'b0, KEY_START1);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hF5);
		with_key(2'd1, 1'b1, KEY_COIN);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hF7);
		with_key(2'd1, 1'b0, KEY_COIN);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hD7);
		with_key(2'd1, 1'b1, KEY_START2_F);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hD7);
		with_key(2'd1, 1'b1, KEY_START2);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hD7);
		with_key(2'd1, 1'b0, KEY_START2_F);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hF7);
		with_key(2'd1, 1'b0, KEY_START2);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hF5);
		with_key(2'd1, 1'b1, KEY_COIN_F);
		add_row(GAME_SPACEZAP, 8'h00, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, COL_0, 8'hF7);
		with_key(2'd1, 1'b0, KEY_COIN_F);
		// Wizard of Wor analog sticks, zone per axis
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0000, 16'h0, COL_2, 8'hFF);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h8000, 16'h0, COL_2, 8'hEE);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h7F00, 16'h0, COL_2, 8'hED);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h007F, 16'h0, COL_2, 8'hE7);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h00A0, 16'h0, COL_2, 8'hFB);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'hC0C0, 16'h0, COL_2, 8'hFF);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h4000, 16'h0, COL_2, 8'hFD);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'hB000, 16'h0, COL_2, 8'hFE);
		add_row(GAME_WOW, 8'h03, 8'h00, 8'h00, 16'h0, 16'h0, 16'h0, 16'h807F, COL_1, 8'hE6);
		// Digital layout back, fire2 uninverted
		add_row(GAME_WOW, 8'h00, 8'h00, 8'h00, 16'h020, 16'h0, 16'h8000, 16'h0, COL_2, 8'hFF);
		add_row(GAME_WOW, 8'h00, 8'h00, 8'h00, 16'h001, 16'h0, 16'h0, 16'h0, COL_2, 8'hE7);
		add_row(GAME_WOW, 8'h00, 8'h00, 8'h00, 16'h030, 16'h0, 16'h0, 16'h0, COL_2, 8'hDF);
		add_row(GAME_WOW, 8'h00, 8'h00, 8'h00, 16'h0, 16'h008, 16'h0, 16'h0, COL_1, 8'hEE);
		// Random joystick rows
		for (int i = 0; i < 18; i++) begin
			add_row((i < 6) ? GAME_SPACEZAP : (i < 12) ? GAME_GORF : GAME_ROBBY, 8'h00,
			        8'h01, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, (i % 2) ? COL_1 : COL_2, 8'h00);
			with_random();
		end
	endtask

	// ==========================================================
	// Apply and compare
	// ==========================================================
	task automatic check_row(input logic [7:0] expected, input logic [7:0] got);
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %0t row_data expected %02h got %02h", $time, expected, got);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [15:0] j0;
		logic [15:0] j1;
		logic [7:0]  expected;
		int          wait_cycles;
		j0       = r.j0;
		j1       = r.j1;
		expected = r.exp;
		if (r.rnd) begin
			j0       = 16'($urandom);
			j1       = 16'($urandom);
			expected = digital_row(r.game, r.d2, r.col, j0, j1);
		end
		// Analog two cycles, keys and game flags one after the last edge
		wait_cycles = (r.a0 != 16'h0 || r.a1 != 16'h0) ? 2 : 1;
		@(posedge clk_sys);
		ioctl_wr    <= 1'b1;
		ioctl_index <= IDX_DIPS;
		ioctl_addr  <= '0;
		ioctl_dout  <= r.d0;
		for (int b = 1; b < NUM_DIP_BANKS; b++) begin
			@(posedge clk_sys);
			ioctl_addr <= 25'(b);
			ioctl_dout <= (b == 2) ? r.d2 : (b == 3) ? r.d3 : 8'h00;
		end
		if (r.stray_en) begin
			@(posedge clk_sys);
			ioctl_index <= r.stray_idx;
			ioctl_addr  <= r.stray_addr;
			ioctl_dout  <= 8'h33;
		end
		// Game id last, flags follow two edges after it is driven
		@(posedge clk_sys);
		ioctl_index <= IDX_GAME_ID;
		ioctl_addr  <= '0;
		ioctl_dout  <= r.game;
		@(posedge clk_sys);
		ioctl_wr          <= 1'b0;
		joystick_0        <= j0;
		joystick_1        <= j1;
		joystick_analog_0 <= r.a0;
		joystick_analog_1 <= r.a1;
		col_select        <= r.col;
		if (r.key_mode == 2'd1) begin
			key_toggle = ~key_toggle;
		end
		if (r.key_mode != 2'd0) begin
			ps2_key <= {key_toggle, r.key_press, r.key_code};
		end
		repeat (wait_cycles) @(posedge clk_sys);
		#1;
		check_row(expected, row_data);
	endtask

	// Watchdog sized by the table
	initial begin
		wait (table_ready === 1'b1);
		#(num_rows * 20 * 40ns);
		$display("simulation timed out before the table finished");
		$display("TEST FAIL");
		$fatal(1);
	end

	initial begin
		ioctl_wr          = 1'b0;
		ioctl_index       = '0;
		ioctl_addr        = '0;
		ioctl_dout        = '0;
		ps2_key           = '0;
		joystick_0        = '0;
		joystick_1        = '0;
		joystick_analog_0 = '0;
		joystick_analog_1 = '0;
		col_select        = COL_0;
		key_toggle        = 1'b0;
		errors            = 0;
		table_ready       = 1'b0;
		void'($urandom(72));
		fill_table();
		table_ready = 1'b1;
		wait (reset === 1'b0);
		for (int i = 0; i < num_rows; i++) begin
			apply_row(table_rows[i]);
		end
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: testbench/astro_input_chk.sv
`timescale 1ns/1ps

module astro_input_chk
	import astro_input_pkg::*;
(
	input logic       clk_sys,
	input logic       reset,
	input logic [7:0] col_select,
	input logic [7:0] row_data,
	input logic       is_spacezap,
	input logic       is_gorf,
	input logic       is_wow,
	input logic       is_robby
);

	logic [3:0] flags;
	logic       col_known;
	logic       col_game;

	assign flags     = {is_spacezap, is_gorf, is_wow, is_robby};
	assign col_game  = (col_select == COL_0) || (col_select == COL_1) || (col_select == COL_2);
	assign col_known = col_game || (col_select == COL_3);

	// ==========================================================
	// Game flags
	// ==========================================================
	flag_onehot: assert property (@(posedge clk_sys) disable iff (reset) $onehot0(flags))
		else $error("more than one game flag is high");

	flag_reset: assert property (@(posedge clk_sys) reset |=> (flags == 4'b0000))
		else $error("game flags not cleared by reset");

	// Row fallbacks
	col_unlisted: assert property (@(posedge clk_sys) disable iff (reset)
		!col_known |-> (row_data == ROW_IDLE))
		else $error("unlisted column did not read idle");

	col_no_game: assert property (@(posedge clk_sys) disable iff (reset)
		(col_game && flags == 4'b0000) |-> (row_data == ROW_IDLE))
		else $error("game column without game did not read idle");

endmodule

bind astro_input_top astro_input_chk astro_input_chk_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.col_select  (col_select),
	.row_data    (row_data),
	.is_spacezap (is_spacezap),
	.is_gorf     (is_gorf),
	.is_wow      (is_wow),
	.is_robby    (is_robby)
);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	localparam time HALF_PERIOD = 20ns; // 40 ns clock
	localparam int  RESET_CYCLES = 5;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Reset held from time zero, dropped on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

// File: rtl/astro_input_top.sv
`timescale 1ns/1ps

module astro_input_top
	import astro_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	input  logic [10:0] ps2_key,
	input  logic [15:0] joystick_0,
	input  logic [15:0] joystick_1,
	input  logic [15:0] joystick_analog_0,
	input  logic [15:0] joystick_analog_1,
	input  logic [7:0]  col_select,
	output logic [7:0]  row_data
);

	logic [7:0]          dip_bank0;
	logic [7:0]          dip_bank2;
	logic [7:0]          dip_bank3;
	logic                is_spacezap;
	logic                is_gorf;
	logic                is_wow;
	logic                is_robby;
	logic [5:0]          key_p1;
	logic [5:0]          key_p2;
	logic                key_start1;
	logic                key_start2;
	logic                key_coin;
	logic [7:0]          paddle [NUM_AXES];
	logic [NUM_AXES-1:0] axis_dir0;
	logic [NUM_AXES-1:0] axis_dir1;
	logic [NUM_AXES-1:0] axis_move;

	// ==========================================================
	// Config and keyboard
	// ==========================================================
	game_select game_select_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_bank0   (dip_bank0),
		.dip_bank2   (dip_bank2),
		.dip_bank3   (dip_bank3),
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_wow      (is_wow),
		.is_robby    (is_robby)
	);

	ps2_button_decoder ps2_button_decoder_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.key_p1     (key_p1),
		.key_p2     (key_p2),
		.key_start1 (key_start1),
		.key_start2 (key_start2),
		.key_coin   (key_coin)
	);

	// Analog path, two register stages
	paddle_conditioner paddle_conditioner_i (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.joystick_analog_0 (joystick_analog_0),
		.joystick_analog_1 (joystick_analog_1),
		.paddle            (paddle)
	);

	for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis
		stick_axis_decoder stick_axis_decoder_i (
			.clk_sys (clk_sys),
			.reset   (reset),
			.paddle  (paddle[g]),
			.dir0    (axis_dir0[g]),
			.dir1    (axis_dir1[g]),
			.move    (axis_move[g])
		);
	end

	control_port_mux control_port_mux_i (
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_wow      (is_wow),
		.is_robby    (is_robby),
		.dip_bank0   (dip_bank0),
		.dip_bank2   (dip_bank2),
		.dip_bank3   (dip_bank3),
		.key_p1      (key_p1),
		.key_p2      (key_p2),
		.key_start1  (key_start1),
		.key_start2  (key_start2),
		.key_coin    (key_coin),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.axis_dir0   (axis_dir0),
		.axis_dir1   (axis_dir1),
		.axis_move   (axis_move),
		.col_select  (col_select), // from the CPU, no register
		.row_data    (row_data)
	);

endmodule

// File: rtl/control_port_mux.sv
`timescale 1ns/1ps

module control_port_mux
	import astro_input_pkg::*;
(
	input  logic                is_spacezap,
	input  logic                is_gorf,
	input  logic                is_wow,
	input  logic                is_robby,
	input  logic [7:0]          dip_bank0,
	input  logic [7:0]          dip_bank2,
	input  logic [7:0]          dip_bank3,
	input  logic [5:0]          key_p1,
	input  logic [5:0]          key_p2,
	input  logic                key_start1,
	input  logic                key_start2,
	input  logic                key_coin,
	input  logic [15:0]         joystick_0,
	input  logic [15:0]         joystick_1,
	input  logic [NUM_AXES-1:0] axis_dir0,
	input  logic [NUM_AXES-1:0] axis_dir1,
	input  logic [NUM_AXES-1:0] axis_move,
	input  logic [7:0]          col_select,
	output logic [7:0]          row_data
);

	logic [5:0] btn_p1;     // R L D U F1 F2
	logic [5:0] btn_p2;
	logic       btn_s1;
	logic       btn_s2;
	logic       btn_coin;
	logic [3:0] p1_dir_n;   // ~R ~L ~D ~U
	logic [3:0] p2_dir_n;
	logic [3:0] w1_dir_n;   // same order, from analog sticks
	logic [3:0] w2_dir_n;
	logic       w1_move;
	logic       w2_move;
	logic       votrax_status;
	logic [7:0] sz_row0, sz_row1, sz_row2;
	logic [7:0] gf_row0, gf_row1, gf_row2;
	logic [7:0] ww_row0, ww_row1, ww_row2;
	logic [7:0] rr_row0, rr_row1, rr_row2;
	logic [7:0] game_row0;
	logic [7:0] game_row1;
	logic [7:0] game_row2;

	// ==========================================================
	// Merged buttons
	// ==========================================================
	assign btn_p1   = key_p1 | joystick_0[5:0];
	assign btn_p2   = key_p2 | joystick_1[5:0];
	assign btn_s1   = key_start1 | joystick_0[6]; // starts and coin on pad 1 only
	assign btn_s2   = key_start2 | joystick_0[7];
	assign btn_coin = key_coin | joystick_0[8];

	assign p1_dir_n = ~{btn_p1[0], btn_p1[1], btn_p1[2], btn_p1[3]};
	assign p2_dir_n = ~{btn_p2[0], btn_p2[1], btn_p2[2], btn_p2[3]};

	// WoW stick, dir1 is up/right and dir0 down/left
	assign w1_dir_n = ~{axis_dir1[AXIS_P1_LR], axis_dir0[AXIS_P1_LR],
	                    axis_dir0[AXIS_P1_UD], axis_dir1[AXIS_P1_UD]};
	assign w2_dir_n = ~{axis_dir1[AXIS_P2_LR], axis_dir0[AXIS_P2_LR],
	                    axis_dir0[AXIS_P2_UD], axis_dir1[AXIS_P2_UD]};
	assign w1_move  = axis_move[AXIS_P1_UD] | axis_move[AXIS_P1_LR]; // either axis at the edge
	assign w2_move  = axis_move[AXIS_P2_UD] | axis_move[AXIS_P2_LR];

	assign votrax_status = 1'b1; // speech chip never busy

	// ==========================================================
	// Per-game rows, bit 7 first
	// ==========================================================
	assign sz_row0 = {2'b11, ~btn_s2, ~btn_s1, dip_bank2[1], 1'b1, ~btn_coin, 1'b1};
	assign sz_row1 = {3'b111, ~btn_p2[4], p2_dir_n};
	assign sz_row2 = {2'b11, dip_bank2[0], ~btn_p1[4], p1_dir_n};

	assign gf_row0 = {1'b0, dip_bank2[0], ~btn_s2, ~btn_s1, 1'b1, dip_bank2[1], ~btn_coin, 1'b1};
	assign gf_row1 = {3'b001, ~btn_p2[4], p2_dir_n};
	assign gf_row2 = {votrax_status, 2'b01, ~btn_p1[4], p1_dir_n};

	assign ww_row0 = {dip_bank2[2], ~btn_s2, ~btn_s1, 1'b1, dip_bank2[1], 1'b1, ~btn_coin, 1'b1};
	// Digital layout keeps fire2 uninverted, as the board reads it
	assign ww_row1 = dip_bank0[1] ? {2'b11, ~btn_p2[4], ~w2_move, w2_dir_n}
	                              : {2'b11, ~btn_p2[4], btn_p2[5], p2_dir_n};
	assign ww_row2 = dip_bank0[0] ? {votrax_status, 1'b1, ~btn_p1[4], ~w1_move, w1_dir_n}
	                              : {votrax_status, 1'b1, ~btn_p1[4], btn_p1[5], p1_dir_n};

	assign rr_row0 = {1'b0, ~btn_s2, ~btn_s1, 1'b1, dip_bank2[1], 1'b1, ~btn_coin, 1'b1};
	assign rr_row1 = {2'b11, ~btn_p2[4], 1'b1, p2_dir_n};
	assign rr_row2 = {2'b11, ~btn_p1[4], 1'b1, p1_dir_n};

	// Game pick, idle with no flag
	always_comb begin
		game_row0 = ROW_IDLE;
		game_row1 = ROW_IDLE;
		game_row2 = ROW_IDLE;
		if (is_spacezap) begin
			game_row0 = sz_row0;
			game_row1 = sz_row1;
			game_row2 = sz_row2;
		end else if (is_gorf) begin
			game_row0 = gf_row0;
			game_row1 = gf_row1;
			game_row2 = gf_row2;
		end else if (is_wow) begin
			game_row0 = ww_row0;
			game_row1 = ww_row1;
			game_row2 = ww_row2;
		end else if (is_robby) begin
			game_row0 = rr_row0;
			game_row1 = rr_row1;
			game_row2 = rr_row2;
		end
	end

	// Column strobe decode
	always_comb begin
		case (col_select)
			COL_0:   row_data = game_row0;
			COL_1:   row_data = game_row1;
			COL_2:   row_data = game_row2;
			COL_3:   row_data = dip_bank3; // every kept game
			default: row_data = ROW_IDLE;
		endcase
	end

endmodule

// File: rtl/stick_axis_decoder.sv
`timescale 1ns/1ps

module stick_axis_decoder
	import astro_input_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] paddle,
	output logic       dir0,   // down or left
	output logic       dir1,   // up or right
	output logic       move
);

	logic [2:0] zone;

	// Eight zones across the travel
	assign zone = paddle[7:5];

	// ==========================================================
	// Zone decode
	// ==========================================================
	// Outer zones also press move, inner ones only steer
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dir0 <= 1'b0;
			dir1 <= 1'b0;
			move <= 1'b0;
		end else begin
			case (zone)
				3'd0: begin
					{dir0, dir1, move} <= 3'b101; // full low
				end
				3'd1: begin
					{dir0, dir1, move} <= 3'b100;
				end
				3'd6: begin
					{dir0, dir1, move} <= 3'b010;
				end
				3'd7: begin
					{dir0, dir1, move} <= 3'b011; // full high
				end
				default: begin
					{dir0, dir1, move} <= 3'b000; // zones 2 to 5 dead
				end
			endcase
		end
	end

endmodule

// File: rtl/paddle_conditioner.sv
`timescale 1ns/1ps

module paddle_conditioner
	import astro_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] joystick_analog_0, // Y high, X low, both signed
	input  logic [15:0] joystick_analog_1,
	output logic [7:0]  paddle [NUM_AXES]
);

	logic [7:0] paddle_next [NUM_AXES];

	// Offset by centre, wraps mod 256 so sign needs no extension
	// Y inverted first, pushing the stick up gives a large paddle
	always_comb begin
		paddle_next[AXIS_P1_UD] = PADDLE_CENTER + ~joystick_analog_0[15:8];
		paddle_next[AXIS_P1_LR] = PADDLE_CENTER + joystick_analog_0[7:0];
		paddle_next[AXIS_P2_UD] = PADDLE_CENTER + ~joystick_analog_1[15:8];
		paddle_next[AXIS_P2_LR] = PADDLE_CENTER + joystick_analog_1[7:0];
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_AXES; i++) begin
				paddle[i] <= PADDLE_CENTER; // centre, dead zone
			end
		end else begin
			for (int i = 0; i < NUM_AXES; i++) begin
				paddle[i] <= paddle_next[i];
			end
		end
	end

endmodule

// File: rtl/ps2_button_decoder.sv
`timescale 1ns/1ps

module ps2_button_decoder
	import astro_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	output logic [5:0]  key_p1,     // R L D U F1 F2 from bit 0
	output logic [5:0]  key_p2,
	output logic        key_start1,
	output logic        key_start2,
	output logic        key_coin
);

	logic       toggle_q; // previous event toggle
	logic       pressed;
	logic [8:0] code;
	logic       start1_f;
	logic       start2_f;
	logic       coin_f;
	logic       start1_m;
	logic       start2_m;
	logic       coin_m;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[8:0];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			key_p1   <= '0;
			key_p2   <= '0;
			start1_f <= 1'b0;
			start2_f <= 1'b0;
			coin_f   <= 1'b0;
			start1_m <= 1'b0;
			start2_m <= 1'b0;
			coin_m   <= 1'b0;
		end else begin
			toggle_q <= ps2_key[10];
			if (toggle_q != ps2_key[10]) begin // new key event
				// Arrows match on low byte only
				case (code[7:0])
					KEY_RIGHT: key_p1[0] <= pressed;
					KEY_LEFT:  key_p1[1] <= pressed;
					KEY_DOWN:  key_p1[2] <= pressed;
					KEY_UP:    key_p1[3] <= pressed;
					default: ;
				endcase
				case (code)
					KEY_FIRE1:    key_p1[4] <= pressed;
					KEY_FIRE2:    key_p1[5] <= pressed;
					KEY_START1_F: start1_f  <= pressed;
					KEY_START2_F: start2_f  <= pressed;
					KEY_COIN_F:   coin_f    <= pressed;
					KEY_START1:   start1_m  <= pressed;
					KEY_START2:   start2_m  <= pressed;
					KEY_COIN:     coin_m    <= pressed;
					KEY_P2_RIGHT: key_p2[0] <= pressed; // player 2 on R D F G
					KEY_P2_LEFT:  key_p2[1] <= pressed;
					KEY_P2_DOWN:  key_p2[2] <= pressed;
					KEY_P2_UP:    key_p2[3] <= pressed;
					KEY_P2_FIRE1: key_p2[4] <= pressed;
					KEY_P2_FIRE2: key_p2[5] <= pressed;
					default: ;
				endcase
			end
		end
	end

	// F-key and MAME codes held independently
	assign key_start1 = start1_f | start1_m;
	assign key_start2 = start2_f | start2_m;
	assign key_coin   = coin_f | coin_m;

endmodule

// File: rtl/game_select.sv
`timescale 1ns/1ps

module game_select
	import astro_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [7:0]  dip_bank0,
	output logic [7:0]  dip_bank2,
	output logic [7:0]  dip_bank3,
	output logic        is_spacezap,
	output logic        is_gorf,
	output logic        is_wow,
	output logic        is_robby
);

	logic [7:0] game_id;                  // last id seen on the loader
	logic [7:0] dip_bank [NUM_DIP_BANKS]; // bank 1 kept but not read by these games

	// Game id capture
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_id <= '0;
		end else if (ioctl_wr && ioctl_index == IDX_GAME_ID) begin
			game_id <= ioctl_dout;
		end
	end

	// DIP bytes, addresses past the last bank dropped
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_DIP_BANKS; i++) begin
				dip_bank[i] <= '0;
			end
		end else if (ioctl_wr && ioctl_index == IDX_DIPS &&
		             ioctl_addr < 25'(NUM_DIP_BANKS)) begin
			dip_bank[ioctl_addr[1:0]] <= ioctl_dout;
		end
	end

	// Flags lag the id by one edge
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			is_spacezap <= 1'b0;
			is_gorf     <= 1'b0;
			is_wow      <= 1'b0;
			is_robby    <= 1'b0;
		end else begin
			is_spacezap <= (game_id == GAME_SPACEZAP);
			is_gorf     <= (game_id == GAME_GORF);
			is_wow      <= (game_id == GAME_WOW);
			is_robby    <= (game_id == GAME_ROBBY);
		end
	end

	assign dip_bank0 = dip_bank[0]; // WoW analog stick enables
	assign dip_bank2 = dip_bank[2];
	assign dip_bank3 = dip_bank[3]; // straight to column 3

endmodule

// File: rtl/astro_input_pkg.sv
package astro_input_pkg;

	// ==========================================================
	// Loader ids and indices
	// ==========================================================
	localparam logic [7:0] GAME_SPACEZAP = 8'd3;
	localparam logic [7:0] GAME_GORF     = 8'd4;
	localparam logic [7:0] GAME_WOW      = 8'd5;
	localparam logic [7:0] GAME_ROBBY    = 8'd6; // ids 1 and 2 select nothing

	localparam logic [7:0] IDX_GAME_ID   = 8'd1;
	localparam logic [7:0] IDX_DIPS      = 8'd254;
	localparam int         NUM_DIP_BANKS = 4;

	// ==========================================================
	// Switch columns
	// ==========================================================
	localparam logic [7:0] COL_0    = 8'h01;
	localparam logic [7:0] COL_1    = 8'h02;
	localparam logic [7:0] COL_2    = 8'h04;
	localparam logic [7:0] COL_3    = 8'h08; // DIP column
	localparam logic [7:0] ROW_IDLE = 8'hFF;

	// Analog sticks
	localparam logic [7:0] PADDLE_CENTER = 8'd128;
	localparam int NUM_AXES   = 4;
	localparam int AXIS_P1_UD = 0;
	localparam int AXIS_P1_LR = 1;
	localparam int AXIS_P2_UD = 2;
	localparam int AXIS_P2_LR = 3;

	// ==========================================================
	// PS/2 codes
	// ==========================================================
	localparam logic [7:0] KEY_UP    = 8'h75; // arrows, E0 prefix ignored
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;

	localparam logic [8:0] KEY_FIRE1    = 9'h014; // ctrl
	localparam logic [8:0] KEY_FIRE2    = 9'h029; // space
	localparam logic [8:0] KEY_START1_F = 9'h005; // F1
	localparam logic [8:0] KEY_START2_F = 9'h006; // F2
	localparam logic [8:0] KEY_COIN_F   = 9'h004; // F3

	// MAME style layout
	localparam logic [8:0] KEY_START1   = 9'h016;
	localparam logic [8:0] KEY_START2   = 9'h01E;
	localparam logic [8:0] KEY_COIN     = 9'h02E;
	localparam logic [8:0] KEY_P2_UP    = 9'h02D;
	localparam logic [8:0] KEY_P2_DOWN  = 9'h02B;
	localparam logic [8:0] KEY_P2_LEFT  = 9'h023;
	localparam logic [8:0] KEY_P2_RIGHT = 9'h034;
	localparam logic [8:0] KEY_P2_FIRE1 = 9'h01C;
	localparam logic [8:0] KEY_P2_FIRE2 = 9'h01B;

endpackage
